// ==== Bender.yml ====
package:
  name: pyr_core

sources:
  - files:
      - pyr_pkg.sv
      - pyr_pc.sv
      - pyr_pipe_ctrl.sv
      - pyr_decode.sv
      - pyr_alu.sv
      - pyr_regfile.sv
      - pyr_core.sv
  - target: test
    files:
      - pyr_tb_clk.sv
      - pyr_tb.sv

// ==== list.f ====
pyr_pkg.sv
pyr_pc.sv
pyr_pipe_ctrl.sv
pyr_decode.sv
pyr_alu.sv
pyr_regfile.sv
pyr_core.sv
pyr_tb_clk.sv
pyr_tb.sv

// ==== pyr_alu.sv ====
//////////////////////////////////////////////////
// operand select and alu
// condition codes and branch decision
// writeback value and jump target
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_alu
	import pyr_pkg::*;
(
	input  logic     valid_2,
	input  opcode_e  opcode,
	input  alu_op_e  alu_op,
	input  br_cond_e cond,
	input  word_t    rs1_val,
	input  word_t    rs2_val,
	input  word_t    imm,
	input  logic     use_imm,
	input  pc_t      pc_2,
	output word_t    rd_val,
	output logic     jump,
	output pc_t      jump_addr
);

	word_t         arg0;
	word_t         arg1;
	word_t         imm_hi;
	word_t         pc_word;
	word_t         res;
	word_t         sra_mask;
	logic [xlen:0] diff_u;
	logic [xlen:0] diff_s;
	logic [3:0]    shamt;
	logic          cc_zero;
	logic          cc_neg;
	logic          cc_borrow;
	logic          taken;

	// upper immediate for lui and auipc
	assign imm_hi  = {imm[xlen-6:0], 5'd0};
	assign pc_word = {{(xlen-palen){1'b0}}, pc_2};

	always_comb begin
		if (opcode == op_auipc) begin
			arg0 = pc_word;
			arg1 = imm_hi;
		end else begin
			arg0 = rs1_val;
			arg1 = use_imm ? imm : rs2_val;
		end
	end

	//////////////////////////////////////////////////
	// subtract and flags
	//////////////////////////////////////////////////

	// one extra bit gives the true sign and the borrow
	assign diff_u = {1'b0, arg0} - {1'b0, arg1};
	assign diff_s = {arg0[xlen-1], arg0} - {arg1[xlen-1], arg1};

	assign cc_zero   = (diff_u[xlen-1:0] == '0);
	assign cc_neg    = diff_s[xlen];
	assign cc_borrow = diff_u[xlen];

	//////////////////////////////////////////////////
	// alu
	//////////////////////////////////////////////////

	assign shamt = arg1[3:0];
	// sign bits filled in above a logical right shift
	assign sra_mask = ~({xlen{1'b1}} >> shamt) & {xlen{arg0[xlen-1]}};

	always_comb begin
		case (alu_op)
			alu_sub:  res = diff_u[xlen-1:0];
			alu_sll:  res = arg0 << shamt;
			alu_slt:  res = {{(xlen-1){1'b0}}, cc_neg};
			alu_sltu: res = {{(xlen-1){1'b0}}, cc_borrow};
			alu_xor:  res = arg0 ^ arg1;
			alu_srl:  res = arg0 >> shamt;
			alu_sra:  res = (arg0 >> shamt) | sra_mask;
			alu_or:   res = arg0 | arg1;
			alu_and:  res = arg0 & arg1;
			default:  res = arg0 + arg1;
		endcase
	end

	// link value is the own address
	always_comb begin
		if (opcode == op_lui)
			rd_val = imm_hi;
		else if (opcode == op_jal || opcode == op_jalr)
			rd_val = pc_word;
		else
			rd_val = res;
	end

	//////////////////////////////////////////////////
	// branch and jump
	//////////////////////////////////////////////////

	always_comb begin
		case (cond)
			br_eq:   taken = cc_zero;
			br_ne:   taken = ~cc_zero;
			br_lt:   taken = cc_neg;
			br_ge:   taken = ~cc_neg;
			br_ltu:  taken = cc_borrow;
			br_geu:  taken = ~cc_borrow;
			default: taken = 1'b0;
		endcase
	end

	// jalr target from the alu sum, others pc relative
	assign jump_addr = (opcode == op_jalr) ? res[palen-1:0] : pc_2 + imm[palen-1:0];

	assign jump = valid_2 & (((opcode == op_br) & taken)
		| (opcode == op_jal) | (opcode == op_jalr));

endmodule

// ==== pyr_core.sv ====
//////////////////////////////////////////////////
// three stage core top level
// fetch, decode, execute and register file
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_core
	import pyr_pkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   run,
	output pc_t    imem_addr,
	input  instr_t imem_dout,
	input  logic   imem_rdy,
	output logic   halt,
	input  rsel_t  dbg_sel,
	output word_t  dbg_dout
);

	// pipeline control
	logic advance;
	logic valid_1;
	logic valid_2;
	logic jump;
	pc_t  jump_addr;
	pc_t  pc_1;
	pc_t  pc_2;

	// decoded stage 2 controls
	opcode_e  opcode;
	alu_op_e  alu_op;
	br_cond_e cond;
	rsel_t    rd;
	rsel_t    rs1;
	rsel_t    rs2;
	word_t    imm;
	logic     use_imm;
	logic     is_halt;
	logic     writes_rd;

	// register data
	word_t rs1_val;
	word_t rs2_val;
	word_t rd_val;
	logic  reg_we;

	// writeback at the end of execute, never once halted
	assign reg_we = valid_2 & writes_rd & run & ~halt;

	pyr_pc pyr_pc_inst (
		.clk        (clk),
		.rst        (rst),
		.advance    (advance),
		.jump       (jump),
		.jump_addr  (jump_addr),
		.fetch_addr (imem_addr),
		.pc_1       (pc_1)
	);

	pyr_pipe_ctrl pyr_pipe_ctrl_inst (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.imem_rdy (imem_rdy),
		.jump     (jump),
		.is_halt  (is_halt),
		.advance  (advance),
		.valid_1  (valid_1),
		.valid_2  (valid_2),
		.halt     (halt)
	);

	pyr_decode pyr_decode_inst (
		.clk       (clk),
		.rst       (rst),
		.advance   (advance),
		.valid_1   (valid_1),
		.imem_dout (imem_dout),
		.pc_1      (pc_1),
		.pc_2      (pc_2),
		.opcode    (opcode),
		.alu_op    (alu_op),
		.cond      (cond),
		.rd        (rd),
		.rs1       (rs1),
		.rs2       (rs2),
		.imm       (imm),
		.use_imm   (use_imm),
		.is_halt   (is_halt),
		.writes_rd (writes_rd)
	);

	pyr_alu pyr_alu_inst (
		.valid_2   (valid_2),
		.opcode    (opcode),
		.alu_op    (alu_op),
		.cond      (cond),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.imm       (imm),
		.use_imm   (use_imm),
		.pc_2      (pc_2),
		.rd_val    (rd_val),
		.jump      (jump),
		.jump_addr (jump_addr)
	);

	pyr_regfile pyr_regfile_inst (
		.clk      (clk),
		.rst      (rst),
		.run      (run),
		.we       (reg_we),
		.rd       (rd),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd_val   (rd_val),
		.dbg_sel  (dbg_sel),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.dbg_dout (dbg_dout)
	);

endmodule

// ==== pyr_decode.sv ====
//////////////////////////////////////////////////
// stage 1 and stage 2 instruction latches
// field split and opcode decode
// immediate build
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_decode
	import pyr_pkg::*;
(
	input  logic     clk,
	input  logic     rst,
	input  logic     advance,
	input  logic     valid_1,
	input  instr_t   imem_dout,
	input  pc_t      pc_1,
	output pc_t      pc_2,
	output opcode_e  opcode,
	output alu_op_e  alu_op,
	output br_cond_e cond,
	output rsel_t    rd,
	output rsel_t    rs1,
	output rsel_t    rs2,
	output word_t    imm,
	output logic     use_imm,
	output logic     is_halt,
	output logic     writes_rd
);

	instr_t     instr_1;
	instr_t     instr_2;
	logic [2:0] funct3;
	logic [2:0] funct7;
	logic [5:0] imm6;
	logic       sgn;
	logic       itype;
	logic       btype;

	//////////////////////////////////////////////////
	// latches
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			instr_1 <= instr_nop;
			instr_2 <= instr_nop;
		end else if (advance) begin
			instr_1 <= imem_dout;
			// bubble becomes a no-op
			instr_2 <= valid_1 ? instr_1 : instr_nop;
		end
	end

	always_ff @(posedge clk) begin
		if (advance)
			pc_2 <= pc_1;
	end

	//////////////////////////////////////////////////
	// fields
	//////////////////////////////////////////////////

	assign opcode = opcode_e'(instr_2[op_msb:op_lsb]);
	assign rd     = instr_2[rd_msb:rd_lsb];
	assign funct3 = instr_2[f3_msb:f3_lsb];
	assign rs1    = instr_2[rs1_msb:rs1_lsb];
	assign rs2    = instr_2[rs2_msb:rs2_lsb];
	assign funct7 = instr_2[f7_msb:f7_lsb];
	assign cond   = br_cond_e'(funct3);

	// only funct3 000 of the system op halts
	assign is_halt   = (opcode == op_sys) && (funct3 == 3'b000);
	assign use_imm   = (opcode == op_imm) || (opcode == op_jalr);
	assign writes_rd = (opcode != op_sys) && (opcode != op_br);

	// add unless a reg or imm op
	always_comb begin
		alu_op = alu_add;
		if (opcode == op_reg || opcode == op_imm) begin
			case (funct3)
				3'b000:  alu_op = (opcode == op_reg && funct7[1]) ? alu_sub : alu_add;
				3'b001:  alu_op = alu_sll;
				3'b010:  alu_op = alu_slt;
				3'b011:  alu_op = alu_sltu;
				3'b100:  alu_op = alu_xor;
				3'b101:  alu_op = funct7[1] ? alu_sra : alu_srl;
				3'b110:  alu_op = alu_or;
				default: alu_op = alu_and;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// immediate
	//////////////////////////////////////////////////

	assign itype = use_imm;
	assign btype = (opcode == op_br);
	assign sgn   = instr_2[f7_msb];

	always_comb begin
		// i type takes the rs2 slot and b type splits around rd
		if (itype)
			imm6 = instr_2[19:14];
		else
			imm6 = {funct7, instr_2[5:3]};
		if (itype || btype)
			imm = {{(xlen-6){sgn}}, imm6};
		else
			imm = {{(xlen-12){sgn}}, instr_2[18:7]};
	end

endmodule

// ==== pyr_pc.sv ====
//////////////////////////////////////////////////
// fetch counter with jump load
// stage 1 address latch
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_pc
	import pyr_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic advance,
	input  logic jump,
	input  pc_t  jump_addr,
	output pc_t  fetch_addr,
	output pc_t  pc_1
);

	// address of the next word to fetch
	pc_t pc_q;

	// target goes out in the same cycle as the jump
	assign fetch_addr = jump ? jump_addr : pc_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q <= '0;
			pc_1 <= '0;
		end else if (advance) begin
			// on a jump the fetched word is dropped, target is fetched again
			if (jump)
				pc_q <= jump_addr;
			else
				pc_q <= pc_q + 1'b1;
			// own address of the word entering stage 1
			pc_1 <= fetch_addr;
		end
	end

endmodule

// ==== pyr_pipe_ctrl.sv ====
//////////////////////////////////////////////////
// run/halt fsm
// stage valid bits, bubbles and flush
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_pipe_ctrl
	import pyr_pkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic run,
	input  logic imem_rdy,
	input  logic jump,
	input  logic is_halt,
	output logic advance,
	output logic valid_1,
	output logic valid_2,
	output logic halt
);

	ctrl_state_e state;
	logic        halt_exec;

	// valid halt sitting in execute
	assign halt_exec = valid_2 & is_halt;

	// pipeline moves on an accepted word or a jump
	// a jump moves it even without imem_rdy, the fetched word is flushed
	assign advance = run & (state == st_running) & (imem_rdy | jump);

	assign halt = (state == st_halted);

	//////////////////////////////////////////////////
	// fsm
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else if (run) begin
			case (state)
				st_idle:    state <= st_running;
				st_running: if (halt_exec) state <= st_halted;
				// only reset leaves halted
				default:    state <= state;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// valid bits
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
		end else if (run) begin
			if (jump || halt_exec || state != st_running) begin
				// flush both younger stages
				valid_1 <= 1'b0;
				valid_2 <= 1'b0;
			end else if (advance) begin
				valid_1 <= 1'b1;
				valid_2 <= valid_1;
			end else begin
				// no fetch, stage 2 has executed, stage 1 waits
				valid_2 <= 1'b0;
			end
		end
	end

endmodule

// ==== pyr_pkg.sv ====
//////////////////////////////////////////////////
// shared widths and typedefs for the core
// instruction field positions
// opcode, alu op, branch condition, fsm enums
//////////////////////////////////////////////////

package pyr_pkg;

	// datapath widths
	localparam int xlen   = 16;
	localparam int ilen   = 21;
	localparam int palen  = 14;
	localparam int rsel_w = 4;
	localparam int nreg   = 16;

	// instruction field positions
	localparam int op_lsb  = 0;
	localparam int op_msb  = 2;
	localparam int rd_lsb  = 3;
	localparam int rd_msb  = 6;
	localparam int f3_lsb  = 7;
	localparam int f3_msb  = 9;
	localparam int rs1_lsb = 10;
	localparam int rs1_msb = 13;
	localparam int rs2_lsb = 14;
	localparam int rs2_msb = 17;
	localparam int f7_lsb  = 18;
	localparam int f7_msb  = 20;

	typedef logic [palen-1:0]  pc_t;
	typedef logic [xlen-1:0]   word_t;
	typedef logic [ilen-1:0]   instr_t;
	typedef logic [rsel_w-1:0] rsel_t;

	// system op with funct3 = 001, does nothing
	localparam instr_t instr_nop = 21'h000080;

	typedef enum logic [2:0] {
		op_sys   = 3'b000,
		op_imm   = 3'b001,
		op_br    = 3'b010,
		op_reg   = 3'b011,
		op_jalr  = 3'b100,
		op_auipc = 3'b101,
		op_jal   = 3'b110,
		op_lui   = 3'b111
	} opcode_e;

	// {sub/arith bit, funct3}
	typedef enum logic [3:0] {
		alu_add  = 4'b0000,
		alu_sll  = 4'b0001,
		alu_slt  = 4'b0010,
		alu_sltu = 4'b0011,
		alu_xor  = 4'b0100,
		alu_srl  = 4'b0101,
		alu_or   = 4'b0110,
		alu_and  = 4'b0111,
		alu_sub  = 4'b1000,
		alu_sra  = 4'b1101
	} alu_op_e;

	// 010 and 011 never branch
	typedef enum logic [2:0] {
		br_eq  = 3'b000,
		br_ne  = 3'b001,
		br_lt  = 3'b100,
		br_ge  = 3'b101,
		br_ltu = 3'b110,
		br_geu = 3'b111
	} br_cond_e;

	typedef enum logic [1:0] {
		st_idle    = 2'b00,
		st_running = 2'b01,
		st_halted  = 2'b10
	} ctrl_state_e;

endpackage

// ==== pyr_regfile.sv ====
//////////////////////////////////////////////////
// sixteen word register file
// two operand reads, one write, debug read
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_regfile
	import pyr_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  run,
	input  logic  we,
	input  rsel_t rd,
	input  rsel_t rs1,
	input  rsel_t rs2,
	input  word_t rd_val,
	input  rsel_t dbg_sel,
	output word_t rs1_val,
	output word_t rs2_val,
	output word_t dbg_dout
);

	word_t regs [nreg];

	// r0 is never written so it stays zero after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < nreg; i++)
				regs[i] <= '0;
		end else if (we && run && rd != '0) begin
			regs[rd] <= rd_val;
		end
	end

	// all reads combinational
	assign rs1_val  = regs[rs1];
	assign rs2_val  = regs[rs2];
	assign dbg_dout = regs[dbg_sel];

endmodule

// ==== pyr_tb.sv ====
//////////////////////////////////////////////////
// testbench for the three stage core
// instruction memory, isa model, random programs
// compare tasks and cycle timeout
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_tb
	import pyr_pkg::*;
;

	// program sizes, words including the final halt
	localparam int alu_words   = 15 + 40 + 1;
	localparam int jump_blocks = 8;
	localparam int jump_words  = 1 + jump_blocks * 9 + 1;
	localparam int br_blocks   = 20;
	localparam int br_words    = 18 + br_blocks * 4 + 1;
	// program 2 runs twice
	localparam int cycle_limit = 40 * (2 * alu_words + jump_words + br_words);
	localparam instr_t halt_instr = '0;

	logic   clk;
	logic   rst;
	logic   restart;
	logic   run;
	logic   imem_rdy;
	logic   halt;
	pc_t    imem_addr;
	instr_t imem_dout;
	rsel_t  dbg_sel;
	word_t  dbg_dout;

	instr_t prog [256];
	instr_t alu_prog [256];
	word_t  mregs [nreg];
	word_t  marker;
	word_t  rv;
	int     n_exec;
	int     errors;
	int     passed;
	int     failed;
	int     err_start;
	int     i;
	int     seed = 72048;
	int     cycles = 0;

	pyr_tb_clk pyr_tb_clk_inst (
		.restart (restart),
		.clk     (clk),
		.rst     (rst)
	);

	pyr_core pyr_core_inst (
		.clk       (clk),
		.rst       (rst),
		.run       (run),
		.imem_addr (imem_addr),
		.imem_dout (imem_dout),
		.imem_rdy  (imem_rdy),
		.halt      (halt),
		.dbg_sel   (dbg_sel),
		.dbg_dout  (dbg_dout)
	);

	// memory answers in the same cycle
	assign imem_dout = prog[imem_addr[7:0]];

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////

	function automatic instr_t reg_instr(input logic [2:0] f3, input logic arith,
		input rsel_t rd, input rsel_t rs1, input rsel_t rs2);
		return {1'b0, arith, 1'b0, rs2, rs1, f3, rd, op_reg};
	endfunction

	// imm7 top bit is the sign, low six bits the value
	function automatic instr_t imm_instr(input opcode_e op, input logic [2:0] f3,
		input rsel_t rd, input rsel_t rs1, input logic [6:0] imm7);
		return {imm7, rs1, f3, rd, op};
	endfunction

	function automatic instr_t upper_instr(input opcode_e op, input rsel_t rd,
		input logic [11:0] u);
		return {u[11], u[11], u, rd, op};
	endfunction

	// offset split around the rd slot
	function automatic instr_t branch_instr(input logic [2:0] f3, input rsel_t rs1,
		input rsel_t rs2, input logic [5:0] off);
		return {off[5:3], rs2, rs1, f3, 1'b0, off[2:0], op_br};
	endfunction

	// r1..r14, keeps r0 and the marker out
	function automatic rsel_t free_reg(input logic [3:0] x);
		return rsel_t'((x % 14) + 1);
	endfunction

	function automatic rsel_t operand_reg(input logic [2:0] x);
		return rsel_t'({1'b0, x} + 4'd1);
	endfunction

	//////////////////////////////////////////////////
	// isa model
	//////////////////////////////////////////////////

	function automatic word_t alu_model(input logic [2:0] f3, input logic arith,
		input word_t a, input word_t b);
		word_t r;
		case (f3)
			3'd0: r = arith ? a - b : a + b;
			3'd1: r = a << b[3:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
			3'd3: r = (a < b) ? 16'd1 : 16'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (arith)
					r = $signed(a) >>> b[3:0];
				else
					r = a >> b[3:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			3'd7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// runs prog in order from address 0 up to the halt
	task automatic run_model;
		pc_t        pc;
		pc_t        next;
		int         k;
		logic       wr;
		logic [2:0] f3;
		instr_t     ins;
		word_t      a;
		word_t      b;
		word_t      wv;
		word_t      immi;
		word_t      immb;
		word_t      immu;
		for (k = 0; k < nreg; k++)
			mregs[k] = '0;
		pc = '0;
		n_exec = 0;
		while (1) begin
			if (pc > 255 || n_exec > 1000) begin
				$display("model ran off the program at address %0d", pc);
				errors++;
				break;
			end
			ins  = prog[pc[7:0]];
			f3   = ins[f3_msb:f3_lsb];
			a    = mregs[ins[rs1_msb:rs1_lsb]];
			b    = mregs[ins[rs2_msb:rs2_lsb]];
			immi = {{10{ins[20]}}, ins[19:14]};
			immb = {{10{ins[20]}}, ins[20:18], ins[5:3]};
			immu = {{4{ins[20]}}, ins[18:7]};
			wr   = 1'b1;
			wv   = '0;
			next = pc + 1'b1;
			n_exec++;
			case (ins[op_msb:op_lsb])
				op_sys: begin
					if (f3 == 3'b000)
						break;
					wr = 1'b0;
				end
				op_imm:   wv = alu_model(f3, (f3 == 3'b101) && ins[19], a, immi);
				op_reg:   wv = alu_model(f3, ins[19], a, b);
				op_br: begin
					wr = 1'b0;
					if (branch_taken(f3, a, b))
						next = pc + immb[palen-1:0];
				end
				op_jalr: begin
					wv   = word_t'(pc);
					next = pc_t'(a + immi);
				end
				op_auipc: wv = word_t'(pc) + (immu << 5);
				op_jal: begin
					wv   = word_t'(pc);
					next = pc + immu[palen-1:0];
				end
				default:  wv = immu << 5;
			endcase
			if (wr && ins[rd_msb:rd_lsb] != '0)
				mregs[ins[rd_msb:rd_lsb]] = wv;
			pc = next;
		end
	endtask

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			$display("ERROR %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// program builders
	//////////////////////////////////////////////////

	// halt words tagged with their own address in the rs1/rs2 slots
	task automatic fill_memory;
		int k;
		for (k = 0; k < 256; k++)
			prog[k] = {3'b000, 8'(k), 10'd0};
	endtask

	task automatic build_alu_program;
		int          k;
		int          wp;
		logic [31:0] r;
		fill_memory;
		wp = 0;
		// large random values first
		for (k = 1; k < 16; k++) begin
			r = $random(seed);
			prog[wp] = upper_instr(op_lui, rsel_t'(k), r[11:0]);
			wp++;
		end
		for (k = 0; k < 40; k++) begin
			r = $random(seed);
			if (r[23])
				prog[wp] = reg_instr(r[2:0], r[3], r[7:4], r[11:8], r[15:12]);
			else
				prog[wp] = imm_instr(op_imm, r[2:0], r[7:4], r[11:8], r[22:16]);
			wp++;
		end
		prog[wp] = halt_instr;
	endtask

	task automatic build_jump_program(output word_t mark);
		int          b;
		int          wp;
		logic [31:0] r;
		fill_memory;
		r = $random(seed);
		// lui keeps the low 11 immediate bits above five zeros
		mark = {r[10:0], 5'd0};
		prog[0] = upper_instr(op_lui, 4'd15, r[11:0]);
		wp = 1;
		for (b = 0; b < jump_blocks; b++) begin
			r = $random(seed);
			prog[wp]     = upper_instr(op_lui, free_reg(r[3:0]), r[15:4]);
			prog[wp + 1] = upper_instr(op_auipc, free_reg(r[19:16]), r[31:20]);
			r = $random(seed);
			// jal over two marker slots
			prog[wp + 2] = upper_instr(op_jal, free_reg(r[3:0]), 12'd3);
			prog[wp + 3] = imm_instr(op_imm, 3'd0, 4'd15, 4'd15, 7'd1);
			prog[wp + 4] = imm_instr(op_imm, 3'd0, 4'd15, 4'd15, 7'd1);
			// jalr from an auipc base, lands past its two slots
			prog[wp + 5] = upper_instr(op_auipc, 4'd14, 12'd0);
			prog[wp + 6] = imm_instr(op_jalr, 3'd0, free_reg(r[7:4]), 4'd14, 7'd4);
			prog[wp + 7] = imm_instr(op_imm, 3'd0, 4'd15, 4'd15, 7'd1);
			prog[wp + 8] = imm_instr(op_imm, 3'd0, 4'd15, 4'd15, 7'd1);
			wp += 9;
		end
		prog[wp] = halt_instr;
	endtask

	task automatic build_branch_program;
		int          k;
		int          wp;
		logic [31:0] r;
		fill_memory;
		wp = 0;
		for (k = 1; k <= 8; k++) begin
			r = $random(seed);
			prog[wp]     = upper_instr(op_lui, rsel_t'(k), r[11:0]);
			prog[wp + 1] = imm_instr(op_imm, 3'd0, rsel_t'(k), rsel_t'(k), r[18:12]);
			wp += 2;
		end
		// equal pairs so eq and ge get taken
		prog[16] = reg_instr(3'd0, 1'b0, 4'd2, 4'd1, 4'd0);
		prog[17] = reg_instr(3'd0, 1'b0, 4'd4, 4'd3, 4'd0);
		wp = 18;
		for (k = 0; k < br_blocks; k++) begin
			r = $random(seed);
			// nudge one operand, then branch over two counters
			prog[wp]     = imm_instr(op_imm, 3'd0, operand_reg(r[2:0]), operand_reg(r[2:0]),
				r[9:3]);
			prog[wp + 1] = branch_instr(r[12:10], operand_reg(r[15:13]), operand_reg(r[18:16]),
				6'd3);
			prog[wp + 2] = imm_instr(op_imm, 3'd0, 4'd9, 4'd9, 7'd1);
			prog[wp + 3] = imm_instr(op_imm, 3'd0, 4'd10, 4'd10, 7'd3);
			wp += 4;
		end
		prog[wp] = halt_instr;
	endtask

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////

	task automatic reset_dut;
		@(posedge clk);
		restart  <= 1'b1;
		run      <= 1'b0;
		imem_rdy <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		@(negedge clk);
		while (rst)
			@(negedge clk);
	endtask

	// count only finished cycles with run and ready both high
	task automatic wait_halt(input logic random_ctl);
		int          accepted;
		logic [31:0] r;
		accepted = 0;
		while (1) begin
			@(posedge clk);
			r = $random(seed);
			if (random_ctl) begin
				run      <= (r[1:0] != 2'b00);
				imem_rdy <= r[2];
			end else begin
				run      <= 1'b1;
				imem_rdy <= 1'b1;
			end
			@(negedge clk);
			if (halt)
				break;
			if (run && imem_rdy)
				accepted++;
		end
		if (accepted < n_exec) begin
			$display("halt rose after %0d fetch cycles but the program executes %0d words",
				accepted, n_exec);
			errors++;
		end
	endtask

	task automatic get_reg(input rsel_t sel, output word_t val);
		@(posedge clk);
		dbg_sel <= sel;
		@(negedge clk);
		val = dbg_dout;
	endtask

	task automatic read_regs;
		int    k;
		word_t v;
		for (k = 0; k < nreg; k++) begin
			get_reg(rsel_t'(k), v);
			check_word($sformatf("dbg_dout r%0d", k), v, mregs[k]);
		end
	endtask

	task automatic report_test(input int num, input string name);
		if (errors == err_start) begin
			passed++;
			$display("test %0d %s: ok", num, name);
		end else begin
			failed++;
			$display("test %0d %s: %0d mismatches", num, name, errors - err_start);
		end
	endtask

	//////////////////////////////////////////////////
	// timeout
	//////////////////////////////////////////////////

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, the core never reached halt", cycles);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		restart  = 1'b0;
		run      = 1'b0;
		imem_rdy = 1'b1;
		dbg_sel  = '0;
		errors   = 0;
		passed   = 0;
		failed   = 0;
		fill_memory;

		// reset state, core held idle
		err_start = errors;
		@(negedge clk);
		while (rst)
			@(negedge clk);
		check_flag("halt", halt, 1'b0);
		check_addr("imem_addr", imem_addr, '0);
		for (i = 0; i < nreg; i++)
			mregs[i] = '0;
		read_regs;
		report_test(1, "reset state");

		err_start = errors;
		build_alu_program;
		alu_prog = prog;
		run_model;
		reset_dut;
		wait_halt(1'b0);
		read_regs;
		report_test(2, "alu program");

		err_start = errors;
		build_jump_program(marker);
		run_model;
		reset_dut;
		wait_halt(1'b0);
		read_regs;
		get_reg(4'd15, rv);
		check_word("dbg_dout r15 marker", rv, marker);
		report_test(3, "upper and jumps");

		err_start = errors;
		build_branch_program;
		run_model;
		reset_dut;
		wait_halt(1'b0);
		read_regs;
		report_test(4, "branches");

		// same program, random run and ready gaps
		err_start = errors;
		prog = alu_prog;
		run_model;
		reset_dut;
		wait_halt(1'b1);
		read_regs;
		report_test(5, "alu program with stalls");

		err_start = errors;
		@(posedge clk);
		run      <= 1'b1;
		imem_rdy <= 1'b1;
		repeat (20) begin
			@(negedge clk);
			check_flag("halt", halt, 1'b1);
		end
		read_regs;
		report_test(6, "hold after halt");

		$display("%0d ok, %0d with mismatches, %0d mismatches in total",
			passed, failed, errors);
		if (failed == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== pyr_tb_clk.sv ====
//////////////////////////////////////////////////
// testbench clock, 10 ns period
// reset held 8 cycles at start and on restart
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pyr_tb_clk (
	input  logic restart,
	output logic clk,
	output logic rst
);

	int cnt;

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		cnt = 0;
	end

	always #5 clk = ~clk;

	// restart opens a fresh 8 cycle reset window
	always @(posedge clk) begin
		if (restart) begin
			rst <= 1'b1;
			cnt <= 0;
		end else if (cnt < 7) begin
			cnt <= cnt + 1;
		end else begin
			rst <= 1'b0;
		end
	end

endmodule
